/* src/tile_pkg.sv */
`default_nettype none

package tile_pkg;

  // --------------------------------------------------------------------------
  // Sizes
  // --------------------------------------------------------------------------
  localparam int DATA_W     = 16;
  localparam int ARCH_REGS  = 8;
  localparam int PHY_REGS   = 16;
  localparam int ROB_DEPTH  = 8;
  localparam int IQ_DEPTH   = 4;
  localparam int MUL_STAGES = 3;

  typedef logic [$clog2(ARCH_REGS)-1:0] arch_idx_t;
  typedef logic [$clog2(PHY_REGS)-1:0]  phy_idx_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

  // Arithmetic wraps modulo 2^DATA_W and MUL keeps the low half
  typedef enum logic [2:0] {
    OP_LI  = 3'd0,
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } op_e;

  // --------------------------------------------------------------------------
  // Packets
  // --------------------------------------------------------------------------
  typedef struct packed {
    op_e               op;
    arch_idx_t         rd;
    arch_idx_t         rs1;
    arch_idx_t         rs2;
    logic [DATA_W-1:0] imm;
  } disp_inst_t;

  // Valid doubles as the occupied bit inside the issue queue
  typedef struct packed {
    logic              valid;
    op_e               op;
    arch_idx_t         rd;
    logic [DATA_W-1:0] imm;
    phy_idx_t          pd;
    phy_idx_t          pd_old;
    phy_idx_t          ps1;
    logic              ps1_rdy;
    phy_idx_t          ps2;
    logic              ps2_rdy;
    rob_idx_t          rob_idx;
  } ren_inst_t;

  typedef struct packed {
    logic              valid;
    phy_idx_t          phy;
    rob_idx_t          rob;
    logic [DATA_W-1:0] value;
  } wb_t;

  typedef struct packed {
    arch_idx_t         rd;
    logic [DATA_W-1:0] value;
  } cmt_t;

endpackage

`default_nettype wire

/* src/dispatch_ctrl.sv */
`default_nettype none

module dispatch_ctrl (
  input  logic i_clk,
  input  logic i_rst,
  input  logic i_disp_req,
  input  logic i_rob_ok,
  input  logic i_iq_ok,
  input  logic i_free_ok,
  output logic o_disp_ack,
  output logic o_alloc
);

  typedef enum logic {
    DS_IDLE,
    DS_ACKED
  } disp_state_e;

  disp_state_e state_q;
  disp_state_e state_d;
  logic        res_ok;

  // Credit check over ROB, issue queue and free list
  assign res_ok = i_rob_ok & i_iq_ok & i_free_ok;

  // One pulse per request since a held req during ack does nothing
  assign o_alloc = (state_q == DS_IDLE) && i_disp_req && res_ok;

  always_comb begin
    state_d = state_q;
    case (state_q)
      DS_IDLE: begin
        if (o_alloc) begin
          state_d = DS_ACKED;
        end
      end
      DS_ACKED: begin
        // Wait for the source to drop req
        if (!i_disp_req) begin
          state_d = DS_IDLE;
        end
      end
      default: state_d = DS_IDLE;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= DS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  assign o_disp_ack = (state_q == DS_ACKED);

endmodule

`default_nettype wire

/* src/rename_map.sv */
`default_nettype none

module rename_map
  import tile_pkg::*;
#(
  parameter int PHY_REGS = tile_pkg::PHY_REGS
) (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_alloc,
  input  disp_inst_t     i_disp_inst,
  input  rob_idx_t       i_rob_tail,
  input  logic [1:0]     i_src_ready,
  input  logic           i_free_valid,
  input  phy_idx_t       i_free_phy,
  output logic           o_free_ok,
  output phy_idx_t [1:0] o_src_phy,
  output ren_inst_t      o_ren
);

  localparam int FL_DEPTH = PHY_REGS - ARCH_REGS;
  localparam int FL_PTR_W = $clog2(FL_DEPTH);

  phy_idx_t            map_q [ARCH_REGS];
  phy_idx_t            fl_q  [FL_DEPTH];
  logic [FL_PTR_W-1:0] fl_head_q;
  logic [FL_PTR_W-1:0] fl_tail_q;
  logic [FL_PTR_W:0]   fl_cnt_q;
  logic                li_op;

  function automatic logic [FL_PTR_W-1:0] fl_next(input logic [FL_PTR_W-1:0] ptr);
    return (ptr == FL_PTR_W'(FL_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_src_phy[0] = map_q[i_disp_inst.rs1];
  assign o_src_phy[1] = map_q[i_disp_inst.rs2];
  assign o_free_ok    = (fl_cnt_q != '0);

  // LI has no register sources
  assign li_op = (i_disp_inst.op == OP_LI);

  always_comb begin
    o_ren.valid   = i_alloc;
    o_ren.op      = i_disp_inst.op;
    o_ren.rd      = i_disp_inst.rd;
    o_ren.imm     = i_disp_inst.imm;
    o_ren.pd      = fl_q[fl_head_q];
    o_ren.pd_old  = map_q[i_disp_inst.rd];
    o_ren.ps1     = o_src_phy[0];
    o_ren.ps1_rdy = i_src_ready[0] | li_op;
    o_ren.ps2     = o_src_phy[1];
    o_ren.ps2_rdy = i_src_ready[1] | li_op;
    o_ren.rob_idx = i_rob_tail;
  end

  // --------------------------------------------------------------------------
  // Map table
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        map_q[i] <= phy_idx_t'(i);
      end
    end else if (i_alloc) begin
      map_q[i_disp_inst.rd] <= fl_q[fl_head_q];
    end
  end

  // --------------------------------------------------------------------------
  // Free list popped at allocation and refilled at commit
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < FL_DEPTH; i++) begin
        fl_q[i] <= phy_idx_t'(ARCH_REGS + i);
      end
      fl_head_q <= '0;
      fl_tail_q <= '0;
      fl_cnt_q  <= (FL_PTR_W + 1)'(FL_DEPTH);
    end else begin
      if (i_alloc) begin
        fl_head_q <= fl_next(fl_head_q);
      end
      if (i_free_valid) begin
        fl_q[fl_tail_q] <= i_free_phy;
        fl_tail_q       <= fl_next(fl_tail_q);
      end
      case ({i_alloc, i_free_valid})
        2'b10:   fl_cnt_q <= fl_cnt_q - 1'b1;
        2'b01:   fl_cnt_q <= fl_cnt_q + 1'b1;
        default: fl_cnt_q <= fl_cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/phy_regfile.sv */
`default_nettype none

module phy_regfile
  import tile_pkg::*;
#(
  parameter int PHY_REGS = tile_pkg::PHY_REGS
) (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  phy_idx_t [1:0]         i_src_phy,
  input  phy_idx_t [1:0]         i_alu_rd,
  input  phy_idx_t [1:0]         i_mul_rd,
  input  wb_t                    i_wb_alu,
  input  wb_t                    i_wb_mul,
  input  logic                   i_clear_valid,
  input  phy_idx_t               i_clear_phy,
  output logic [1:0]             o_src_ready,
  output logic [1:0][DATA_W-1:0] o_alu_val,
  output logic [1:0][DATA_W-1:0] o_mul_val
);

  logic [DATA_W-1:0]   regs_q [PHY_REGS];
  logic [PHY_REGS-1:0] ready_q;

  always_comb begin
    for (int s = 0; s < 2; s++) begin
      // A writeback in flight this cycle already counts as ready
      o_src_ready[s] = ready_q[i_src_phy[s]]
                     | (i_wb_alu.valid && (i_wb_alu.phy == i_src_phy[s]))
                     | (i_wb_mul.valid && (i_wb_mul.phy == i_src_phy[s]));
      o_alu_val[s]   = regs_q[i_alu_rd[s]];
      o_mul_val[s]   = regs_q[i_mul_rd[s]];
    end
  end

  // Arch registers start mapped 1:1 and hold zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int p = 0; p < PHY_REGS; p++) begin
        regs_q[p]  <= '0;
        ready_q[p] <= (p < ARCH_REGS);
      end
    end else begin
      if (i_clear_valid) begin
        ready_q[i_clear_phy] <= 1'b0;
      end
      if (i_wb_alu.valid) begin
        regs_q[i_wb_alu.phy]  <= i_wb_alu.value;
        ready_q[i_wb_alu.phy] <= 1'b1;
      end
      if (i_wb_mul.valid) begin
        regs_q[i_wb_mul.phy]  <= i_wb_mul.value;
        ready_q[i_wb_mul.phy] <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* src/issue_queue.sv */
`default_nettype none

module issue_queue
  import tile_pkg::*;
#(
  parameter int IQ_DEPTH = tile_pkg::IQ_DEPTH
) (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_alloc,
  input  ren_inst_t      i_ren,
  input  wb_t            i_wb_alu,
  input  wb_t            i_wb_mul,
  output logic           o_iq_ok,
  output ren_inst_t      o_alu_issue,
  output ren_inst_t      o_mul_issue,
  output phy_idx_t [1:0] o_alu_rd,
  output phy_idx_t [1:0] o_mul_rd
);

  ren_inst_t           ent_q   [IQ_DEPTH];
  // older_q[i][j] is set when entry i arrived before entry j
  logic [IQ_DEPTH-1:0] older_q [IQ_DEPTH];
  logic [IQ_DEPTH-1:0] ent_free;
  logic [IQ_DEPTH-1:0] alloc_sel;
  logic [IQ_DEPTH-1:0] alu_rdy;
  logic [IQ_DEPTH-1:0] mul_rdy;
  logic [IQ_DEPTH-1:0] alu_sel;
  logic [IQ_DEPTH-1:0] mul_sel;

  function automatic logic woken(input phy_idx_t phy);
    return (i_wb_alu.valid && (i_wb_alu.phy == phy)) ||
           (i_wb_mul.valid && (i_wb_mul.phy == phy));
  endfunction

  always_comb begin
    for (int i = 0; i < IQ_DEPTH; i++) begin
      ent_free[i] = !ent_q[i].valid;
      alu_rdy[i]  = ent_q[i].valid && ent_q[i].ps1_rdy && ent_q[i].ps2_rdy &&
                    (ent_q[i].op != OP_MUL);
      mul_rdy[i]  = ent_q[i].valid && ent_q[i].ps1_rdy && ent_q[i].ps2_rdy &&
                    (ent_q[i].op == OP_MUL);
    end
  end

  // Lowest free slot takes the next instruction
  assign alloc_sel = ent_free & (~ent_free + 1'b1);
  assign o_iq_ok   = |ent_free;

  // --------------------------------------------------------------------------
  // Oldest ready entry per path
  // --------------------------------------------------------------------------
  always_comb begin
    alu_sel = alu_rdy;
    mul_sel = mul_rdy;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      for (int j = 0; j < IQ_DEPTH; j++) begin
        if (alu_rdy[j] && older_q[j][i]) begin
          alu_sel[i] = 1'b0;
        end
        if (mul_rdy[j] && older_q[j][i]) begin
          mul_sel[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    o_alu_issue = '0;
    o_mul_issue = '0;
    for (int i = 0; i < IQ_DEPTH; i++) begin
      if (alu_sel[i]) begin
        o_alu_issue = ent_q[i];
      end
      if (mul_sel[i]) begin
        o_mul_issue = ent_q[i];
      end
    end
  end

  assign o_alu_rd = {o_alu_issue.ps2, o_alu_issue.ps1};
  assign o_mul_rd = {o_mul_issue.ps2, o_mul_issue.ps1};

  // --------------------------------------------------------------------------
  // Entry storage and wakeup
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < IQ_DEPTH; i++) begin
        ent_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < IQ_DEPTH; i++) begin
        if (i_alloc && alloc_sel[i]) begin
          ent_q[i] <= i_ren;
        end else begin
          if (alu_sel[i] || mul_sel[i]) begin
            ent_q[i].valid <= 1'b0;
          end
          if (woken(ent_q[i].ps1)) begin
            ent_q[i].ps1_rdy <= 1'b1;
          end
          if (woken(ent_q[i].ps2)) begin
            ent_q[i].ps2_rdy <= 1'b1;
          end
        end
      end
    end
  end

  // New entry is younger than everything already queued
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      for (int i = 0; i < IQ_DEPTH; i++) begin
        for (int j = 0; j < IQ_DEPTH; j++) begin
          if (alloc_sel[i]) begin
            older_q[i][j] <= 1'b0;
          end else if (alloc_sel[j]) begin
            older_q[i][j] <= 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* src/exec_pipe.sv */
`default_nettype none

module exec_pipe
  import tile_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  ren_inst_t              i_alu_issue,
  input  ren_inst_t              i_mul_issue,
  input  logic [1:0][DATA_W-1:0] i_alu_val,
  input  logic [1:0][DATA_W-1:0] i_mul_val,
  output wb_t                    o_wb_alu,
  output wb_t                    o_wb_mul
);

  logic [DATA_W-1:0] alu_res;
  logic [DATA_W-1:0] mul_prod;
  wb_t               mul_q [MUL_STAGES];

  // --------------------------------------------------------------------------
  // Single-cycle ALU
  // --------------------------------------------------------------------------
  always_comb begin
    case (i_alu_issue.op)
      OP_LI:   alu_res = i_alu_issue.imm;
      OP_ADD:  alu_res = i_alu_val[0] + i_alu_val[1];
      OP_SUB:  alu_res = i_alu_val[0] - i_alu_val[1];
      OP_AND:  alu_res = i_alu_val[0] & i_alu_val[1];
      OP_XOR:  alu_res = i_alu_val[0] ^ i_alu_val[1];
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_wb_alu.valid <= 1'b0;
    end else begin
      o_wb_alu.valid <= i_alu_issue.valid;
      o_wb_alu.phy   <= i_alu_issue.pd;
      o_wb_alu.rob   <= i_alu_issue.rob_idx;
      o_wb_alu.value <= alu_res;
    end
  end

  // --------------------------------------------------------------------------
  // Multiplier takes one new op per cycle and settles the product in stage 0
  // --------------------------------------------------------------------------
  assign mul_prod = i_mul_val[0] * i_mul_val[1];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int s = 0; s < MUL_STAGES; s++) begin
        mul_q[s].valid <= 1'b0;
      end
    end else begin
      mul_q[0].valid <= i_mul_issue.valid;
      mul_q[0].phy   <= i_mul_issue.pd;
      mul_q[0].rob   <= i_mul_issue.rob_idx;
      mul_q[0].value <= mul_prod;
      for (int s = 1; s < MUL_STAGES; s++) begin
        mul_q[s] <= mul_q[s-1];
      end
    end
  end

  assign o_wb_mul = mul_q[MUL_STAGES-1];

endmodule

`default_nettype wire

/* src/reorder_buffer.sv */
`default_nettype none

module reorder_buffer
  import tile_pkg::*;
#(
  parameter int ROB_DEPTH = tile_pkg::ROB_DEPTH
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_alloc,
  input  ren_inst_t i_ren,
  input  wb_t       i_wb_alu,
  input  wb_t       i_wb_mul,
  output logic      o_rob_ok,
  output rob_idx_t  o_rob_tail,
  output logic      o_cmt_valid,
  output cmt_t      o_cmt,
  output logic      o_free_valid,
  output phy_idx_t  o_free_phy
);

  localparam int CNT_W = $clog2(ROB_DEPTH + 1);

  arch_idx_t            rd_q     [ROB_DEPTH];
  phy_idx_t             pd_old_q [ROB_DEPTH];
  logic [DATA_W-1:0]    value_q  [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done_q;
  rob_idx_t             head_q;
  rob_idx_t             tail_q;
  logic [CNT_W-1:0]     cnt_q;
  logic                 commit;

  function automatic rob_idx_t rob_next(input rob_idx_t idx);
    return (idx == rob_idx_t'(ROB_DEPTH - 1)) ? '0 : idx + 1'b1;
  endfunction

  // Head retires once its result is in
  assign commit       = (cnt_q != '0) && done_q[head_q];
  assign o_rob_ok     = (cnt_q != CNT_W'(ROB_DEPTH));
  assign o_rob_tail   = tail_q;
  assign o_free_valid = o_cmt_valid;

  // --------------------------------------------------------------------------
  // Entry payload
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_alloc) begin
      rd_q[tail_q]     <= i_ren.rd;
      pd_old_q[tail_q] <= i_ren.pd_old;
    end
    if (i_wb_alu.valid) begin
      value_q[i_wb_alu.rob] <= i_wb_alu.value;
    end
    if (i_wb_mul.valid) begin
      value_q[i_wb_mul.rob] <= i_wb_mul.value;
    end
    if (commit) begin
      o_cmt.rd    <= rd_q[head_q];
      o_cmt.value <= value_q[head_q];
      o_free_phy  <= pd_old_q[head_q];
    end
  end

  // --------------------------------------------------------------------------
  // Pointers, done bits and commit pulse
  // --------------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      done_q      <= '0;
      head_q      <= '0;
      tail_q      <= '0;
      cnt_q       <= '0;
      o_cmt_valid <= 1'b0;
    end else begin
      if (i_alloc) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= rob_next(tail_q);
      end
      if (i_wb_alu.valid) begin
        done_q[i_wb_alu.rob] <= 1'b1;
      end
      if (i_wb_mul.valid) begin
        done_q[i_wb_mul.rob] <= 1'b1;
      end
      if (commit) begin
        head_q <= rob_next(head_q);
      end
      o_cmt_valid <= commit;
      case ({i_alloc, commit})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/core_tile.sv */
`default_nettype none

module core_tile
  import tile_pkg::*;
#(
  parameter int ROB_DEPTH = tile_pkg::ROB_DEPTH,
  parameter int IQ_DEPTH  = tile_pkg::IQ_DEPTH,
  parameter int PHY_REGS  = tile_pkg::PHY_REGS
) (
  input  logic       i_clk,
  input  logic       i_rst,
  input  logic       i_disp_req,
  input  disp_inst_t i_disp_inst,
  output logic       o_disp_ack,
  output logic       o_cmt_valid,
  output cmt_t       o_cmt
);

  // --------------------------------------------------------------------------
  // Dispatch and rename
  // --------------------------------------------------------------------------
  logic                   w_alloc;
  logic                   w_rob_ok;
  logic                   w_iq_ok;
  logic                   w_free_ok;
  rob_idx_t               w_rob_tail;
  ren_inst_t              w_ren;
  phy_idx_t [1:0]         w_src_phy;
  logic [1:0]             w_src_ready;

  // --------------------------------------------------------------------------
  // Issue, execute and writeback
  // --------------------------------------------------------------------------
  ren_inst_t              w_alu_issue;
  ren_inst_t              w_mul_issue;
  phy_idx_t [1:0]         w_alu_rd;
  phy_idx_t [1:0]         w_mul_rd;
  logic [1:0][DATA_W-1:0] w_alu_val;
  logic [1:0][DATA_W-1:0] w_mul_val;
  wb_t                    w_wb_alu;
  wb_t                    w_wb_mul;

  // Old destination returned at commit
  logic                   w_free_valid;
  phy_idx_t               w_free_phy;

  dispatch_ctrl u_dispatch_ctrl (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_disp_req (i_disp_req),
    .i_rob_ok   (w_rob_ok),
    .i_iq_ok    (w_iq_ok),
    .i_free_ok  (w_free_ok),
    .o_disp_ack (o_disp_ack),
    .o_alloc    (w_alloc)
  );

  rename_map #(
    .PHY_REGS (PHY_REGS)
  ) u_rename_map (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_alloc      (w_alloc),
    .i_disp_inst  (i_disp_inst),
    .i_rob_tail   (w_rob_tail),
    .i_src_ready  (w_src_ready),
    .i_free_valid (w_free_valid),
    .i_free_phy   (w_free_phy),
    .o_free_ok    (w_free_ok),
    .o_src_phy    (w_src_phy),
    .o_ren        (w_ren)
  );

  phy_regfile #(
    .PHY_REGS (PHY_REGS)
  ) u_phy_regfile (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_src_phy     (w_src_phy),
    .i_alu_rd      (w_alu_rd),
    .i_mul_rd      (w_mul_rd),
    .i_wb_alu      (w_wb_alu),
    .i_wb_mul      (w_wb_mul),
    .i_clear_valid (w_free_valid),
    .i_clear_phy   (w_free_phy),
    .o_src_ready   (w_src_ready),
    .o_alu_val     (w_alu_val),
    .o_mul_val     (w_mul_val)
  );

  issue_queue #(
    .IQ_DEPTH (IQ_DEPTH)
  ) u_issue_queue (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_alloc     (w_alloc),
    .i_ren       (w_ren),
    .i_wb_alu    (w_wb_alu),
    .i_wb_mul    (w_wb_mul),
    .o_iq_ok     (w_iq_ok),
    .o_alu_issue (w_alu_issue),
    .o_mul_issue (w_mul_issue),
    .o_alu_rd    (w_alu_rd),
    .o_mul_rd    (w_mul_rd)
  );

  exec_pipe u_exec_pipe (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_alu_issue (w_alu_issue),
    .i_mul_issue (w_mul_issue),
    .i_alu_val   (w_alu_val),
    .i_mul_val   (w_mul_val),
    .o_wb_alu    (w_wb_alu),
    .o_wb_mul    (w_wb_mul)
  );

  reorder_buffer #(
    .ROB_DEPTH (ROB_DEPTH)
  ) u_reorder_buffer (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_alloc      (w_alloc),
    .i_ren        (w_ren),
    .i_wb_alu     (w_wb_alu),
    .i_wb_mul     (w_wb_mul),
    .o_rob_ok     (w_rob_ok),
    .o_rob_tail   (w_rob_tail),
    .o_cmt_valid  (o_cmt_valid),
    .o_cmt        (o_cmt),
    .o_free_valid (w_free_valid),
    .o_free_phy   (w_free_phy)
  );

endmodule

`default_nettype wire

/* verification/core_tile_tb.sv */
`default_nettype none

module core_tile_tb
  import tile_pkg::*;
();

  localparam int         STIM_WORDS = 64;
  localparam int         RAND_COUNT = 40;
  localparam logic [3:0] KIND_INST  = 4'h0;
  localparam logic [3:0] KIND_MARK  = 4'h1;
  localparam logic [3:0] KIND_END   = 4'hf;

  logic              i_clk;
  logic              i_rst;
  logic              i_disp_req;
  disp_inst_t        i_disp_inst;
  logic              o_disp_ack;
  logic              o_cmt_valid;
  cmt_t              o_cmt;

  logic [51:0]       stim_mem [STIM_WORDS];
  logic [51:0]       word;
  logic [DATA_W-1:0] arch_model [ARCH_REGS];
  arch_idx_t         exp_rd_q [$];
  logic [DATA_W-1:0] exp_val_q [$];
  arch_idx_t         exp_rd;
  logic [DATA_W-1:0] exp_val;
  logic [DATA_W-1:0] model_val;
  logic [31:0]       rnd;
  disp_inst_t        inst;
  logic              req_at_edge = 1'b0;
  logic              ack_prev = 1'b0;
  logic              test_open = 1'b0;
  int                errors = 0;
  int                errs_at_start = 0;
  int                cur_test = 0;
  int                stall_cycles = 0;
  int                tests_passed = 0;
  int                tests_failed = 0;
  int                file_inst = 0;
  int                cycle_cnt = 0;
  int                cycle_limit = 0;

  core_tile core_tile_i (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_disp_req  (i_disp_req),
    .i_disp_inst (i_disp_inst),
    .o_disp_ack  (o_disp_ack),
    .o_cmt_valid (o_cmt_valid),
    .o_cmt       (o_cmt)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Reference for the op rules with every result wrapping at 16 bits
  function automatic logic [DATA_W-1:0] expected_result(input op_e op,
      input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
      input logic [DATA_W-1:0] imm);
    case (op)
      OP_LI:   return imm;
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_MUL:  return a * b;
      default: return '0;
    endcase
  endfunction

  // --------------------------------------------------------------------------
  // Dispatch driver and test bookkeeping
  // --------------------------------------------------------------------------
  task automatic send_inst(input disp_inst_t inst_in, input logic [DATA_W-1:0] value);
    exp_rd_q.push_back(inst_in.rd);
    exp_val_q.push_back(value);
    arch_model[inst_in.rd] = value;
    i_disp_inst = inst_in;
    i_disp_req  = 1'b1;
    @(negedge i_clk);
    // Req and data stay held while a resource is full
    while (!o_disp_ack) begin
      stall_cycles++;
      @(negedge i_clk);
    end
    i_disp_req = 1'b0;
    @(negedge i_clk);
    while (o_disp_ack) begin
      @(negedge i_clk);
    end
  endtask

  task automatic begin_test(input int num);
    cur_test      = num;
    errs_at_start = errors;
    stall_cycles  = 0;
    test_open     = 1'b1;
  endtask

  task automatic finish_test();
    int test_errs;
    while (exp_rd_q.size() != 0) begin
      @(negedge i_clk);
    end
    @(negedge i_clk);
    if (cur_test == 4 && stall_cycles == 0) begin
      $display("Test 4 never saw dispatch held back by a full resource");
      errors++;
    end
    test_errs = errors - errs_at_start;
    if (test_errs == 0) begin
      $display("test %0d: passed", cur_test);
      tests_passed++;
    end else begin
      $display("test %0d: failed with %0d errors", cur_test, test_errs);
      tests_failed++;
    end
    test_open = 1'b0;
  endtask

  // --------------------------------------------------------------------------
  // Monitors
  // --------------------------------------------------------------------------
  always @(posedge i_clk) begin
    req_at_edge <= i_disp_req;
  end

  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_disp_ack && !ack_prev && !req_at_edge) begin
        $display("Ack rose while req was low at time %0t", $time);
        errors++;
      end
      if (o_disp_ack && ack_prev && !req_at_edge) begin
        $display("Ack stayed high after req fell at time %0t", $time);
        errors++;
      end
      if (!o_disp_ack && ack_prev && req_at_edge) begin
        $display("Ack fell while req was still high at time %0t", $time);
        errors++;
      end
    end
    ack_prev <= o_disp_ack;
  end

  // Commits must match the program order of dispatch
  always @(negedge i_clk) begin
    if (!i_rst && o_cmt_valid) begin
      if (exp_rd_q.size() == 0) begin
        $display("Commit at time %0t with no instruction outstanding", $time);
        errors++;
      end else begin
        exp_rd  = exp_rd_q.pop_front();
        exp_val = exp_val_q.pop_front();
        if (o_cmt.rd !== exp_rd) begin
          $display("FAIL t=%0t o_cmt.rd got %0d expected %0d", $time, o_cmt.rd, exp_rd);
          errors++;
        end
        if (o_cmt.value !== exp_val) begin
          $display("FAIL t=%0t o_cmt.value got %h expected %h", $time, o_cmt.value,
                   exp_val);
          errors++;
        end
      end
    end
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("Run stopped after %0d cycles, commits stopped arriving (%0d outstanding)",
               cycle_cnt, exp_rd_q.size());
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    i_rst       = 1'b1;
    i_disp_req  = 1'b0;
    i_disp_inst = '0;
    inst        = '0;
    for (int i = 0; i < ARCH_REGS; i++) begin
      arch_model[i] = '0;
    end
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim_mem[i] = {KIND_END, 48'(i)};
    end
    $readmemh("verification/tile_stimulus.dat", stim_mem);
    for (int i = 0; i < STIM_WORDS; i++) begin
      if (stim_mem[i][51:48] == KIND_INST) begin
        file_inst++;
      end
    end
    cycle_limit = 30 * (file_inst + RAND_COUNT) + 200;

    repeat (3) @(negedge i_clk);
    i_rst = 1'b0;

    // Idle outputs before the first request
    begin_test(1);
    repeat (6) begin
      @(negedge i_clk);
      if (o_disp_ack !== 1'b0) begin
        $display("FAIL t=%0t o_disp_ack got %b expected 0", $time, o_disp_ack);
        errors++;
      end
      if (o_cmt_valid !== 1'b0) begin
        $display("FAIL t=%0t o_cmt_valid got %b expected 0", $time, o_cmt_valid);
        errors++;
      end
    end
    finish_test();

    for (int i = 0; i < STIM_WORDS && stim_mem[i][51:48] != KIND_END; i++) begin
      word = stim_mem[i];
      if (word[51:48] == KIND_MARK) begin
        if (test_open) begin
          finish_test();
        end
        begin_test(int'(word[15:0]));
      end else begin
        inst.op  = op_e'(word[46:44]);
        inst.rd  = word[42:40];
        inst.rs1 = word[38:36];
        inst.rs2 = word[34:32];
        inst.imm = word[31:16];
        send_inst(inst, word[15:0]);
      end
    end
    if (test_open) begin
      finish_test();
    end

    // Random mix where the model carries on from the file tests
    begin_test(5);
    rnd = 32'hce18;
    for (int n = 0; n < RAND_COUNT; n++) begin
      rnd       = xorshift32(rnd);
      inst.op   = op_e'(3'(rnd % 32'd6));
      inst.rd   = rnd[5:3];
      inst.rs1  = rnd[8:6];
      inst.rs2  = rnd[11:9];
      inst.imm  = rnd[27:12];
      model_val = expected_result(inst.op, arch_model[inst.rs1], arch_model[inst.rs2],
                                  inst.imm);
      send_inst(inst, model_val);
    end
    finish_test();

    $display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/tile_stimulus.dat */
// One 13-digit word per line: kind, op, rd, rs1, rs2 (a digit each), imm, expected commit value
// Kind 0 is an instruction, kind 1 starts the test in the last four digits; ops 0-5 li add sub and xor mul
1000000000002 // test 2, dependent ALU chain
0010012341234 // li  r1, 0x1234
002000F0F0F0F // li  r2, 0x0f0f
0131200002143 // add r3, r1, r2
024230000EDCC // sub r4, r2, r3
0354300002140 // and r5, r4, r3
0465100003374 // xor r6, r5, r1
1000000000003 // test 3, mul overtaken by adds
0571200001D0C // mul r7, r1, r2
0113400000F0F // add r1, r3, r4
01256000054B4 // add r2, r5, r6
0131100001E1E // add r3, r1, r1
1000000000004 // test 4, dependent mul chain
0020000010001 // li  r2, 1
0030000030003 // li  r3, 3
0522300000003 // mul r2, r2, r3
0522300000009
052230000001B
0522300000051
05223000000F3
05223000002D9
052230000088B
05223000019A1
0522300004CE3
052230000E6A9
052230000B3FB
0522300001BF1

/* sources.f */
src/tile_pkg.sv
src/dispatch_ctrl.sv
src/rename_map.sv
src/phy_regfile.sv
src/issue_queue.sv
src/exec_pipe.sv
src/reorder_buffer.sv
src/core_tile.sv
verification/core_tile_tb.sv
